/* design/lsu_bus_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// data bus widths of the load/store unit
// vector types for addresses, data words and byte enables
////////////////////////////////////////////////////////////////////////////

package lsu_bus_pkg;

  // bus geometry
  localparam int unsigned ADDR_W = 32;         // byte address
  localparam int unsigned DATA_W = 32;         // one bus word
  localparam int unsigned BE_W   = DATA_W / 8; // one enable per byte lane

  // byte address as computed by the core
  typedef logic [ADDR_W-1:0] addr_t;

  // core or bus data word
  typedef logic [DATA_W-1:0] data_t;

  // lane enables, bit 0 is the lowest byte
  typedef logic [BE_W-1:0] be_t;

endpackage

/* design/lsu_access_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// access size codes and byte offset type
// split rule constants and controller state encoding
////////////////////////////////////////////////////////////////////////////

package lsu_access_pkg;

  // size of a core access
  typedef logic [1:0] mem_type_t;

  localparam mem_type_t TYPE_WORD = 2'b00;
  localparam mem_type_t TYPE_HALF = 2'b01;
  localparam mem_type_t TYPE_BYTE = 2'b10; // code 11 decodes as byte as well

  // byte position inside a bus word
  typedef logic [1:0] offset_t;

  localparam offset_t OFFSET_ALIGNED    = 2'b00; // word at this offset fits one transfer
  localparam offset_t OFFSET_HALF_SPLIT = 2'b11; // half word here crosses into next word

  // access controller states
  typedef enum logic [2:0] {
    IDLE,             // waiting for a core request
    WAIT_GNT_MIS,     // first part of a split access requested
    WAIT_RVALID_MIS,  // first part granted, second part requested
    WAIT_GNT,         // single or second part requested
    WAIT_RVALID,      // last response outstanding
    WAIT_RVALID_DONE  // both granted, first response outstanding
  } ls_fsm_e;

endpackage

/* design/lsu_access_if.sv */
////////////////////////////////////////////////////////////////////////////
// attributes of the current access, shared by controller and aligners
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface lsu_access_if
  import lsu_access_pkg::*;
();

  mem_type_t acc_type;     // size of the access
  offset_t   acc_offset;   // byte offset of the core address
  logic      acc_sign_ext; // sign extend halves and bytes
  logic      acc_we;       // store when high
  logic      second_part;  // split access past its first grant
  logic      ctrl_update;  // grant strobe, capture attributes
  logic      rdata_update; // first response of a split access

  modport ctrl (
    output acc_type, acc_offset, acc_sign_ext, acc_we,
    output second_part, ctrl_update, rdata_update
  );

  modport store (
    input acc_type, acc_offset, second_part
  );

  modport load (
    input acc_type, acc_offset, acc_sign_ext, acc_we, ctrl_update, rdata_update
  );

endinterface

/* design/lsu_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// load/store access controller
// split decision, bus request FSM, second part address and error collection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_ctrl
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // core side
  input  logic      data_req_ex_i,
  input  mem_type_t data_type_ex_i,
  input  logic      data_we_ex_i,
  input  logic      data_sign_ext_ex_i,
  input  addr_t     addr_ex_i,
  // bus side
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  logic      data_err_i,
  output logic      data_req_o,
  output addr_t     data_addr_o,
  // completion
  output logic      data_valid_o,
  output logic      load_err_o,
  output logic      store_err_o,
  output logic      busy_o,
  lsu_access_if.ctrl acc
);

  offset_t offset;
  addr_t   addr_aligned;
  logic    split_access;                 // access needs two bus transfers
  logic    second_part_q, second_part_d; // set from first grant to completion
  logic    lsu_err_q, lsu_err_d;         // error seen on the first part
  logic    access_err;                   // error of either part, final cycle only
  logic    ctrl_update;
  logic    rdata_update;

  ls_fsm_e ls_fsm_cs, ls_fsm_ns;

  assign offset       = addr_ex_i[$bits(offset_t)-1:0];
  assign addr_aligned = {addr_ex_i[ADDR_W-1:$bits(offset_t)], {$bits(offset_t){1'b0}}};

  // word not on a word boundary, or half word straddling lanes 3 and 0
  assign split_access =
      ((data_type_ex_i == TYPE_WORD) && (offset != OFFSET_ALIGNED)) ||
      ((data_type_ex_i == TYPE_HALF) && (offset == OFFSET_HALF_SPLIT));

  // second part always goes to the following word
  assign data_addr_o = second_part_q ? addr_aligned + ADDR_W'(BE_W) : addr_aligned;

  ////////////////////////////////////////////////////////////////////////////
  // access FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ls_fsm_ns     = ls_fsm_cs;
    second_part_d = second_part_q;
    lsu_err_d     = lsu_err_q;
    data_req_o    = 1'b0;
    data_valid_o  = 1'b0;
    access_err    = 1'b0;
    ctrl_update   = 1'b0;
    rdata_update  = 1'b0;

    unique case (ls_fsm_cs)
      IDLE: begin
        if (data_req_ex_i) begin
          data_req_o = 1'b1;  // straight from the core request, no extra cycle
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update   = 1'b1;
            second_part_d = split_access;
            ls_fsm_ns     = split_access ? WAIT_RVALID_MIS : WAIT_RVALID;
          end else begin
            ls_fsm_ns     = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1; // hold first part until granted
        if (data_gnt_i) begin
          ctrl_update   = 1'b1;
          second_part_d = 1'b1;
          ls_fsm_ns     = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        // second part goes out while the first response is pending
        data_req_o  = 1'b1;
        ctrl_update = data_gnt_i;
        if (data_rvalid_i) begin
          lsu_err_d    = data_err_i;
          rdata_update = 1'b1;
          ls_fsm_ns    = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end else if (data_gnt_i) begin
          ls_fsm_ns    = WAIT_RVALID_DONE; // two transfers now outstanding
        end
      end

      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update = 1'b1;
          ls_fsm_ns   = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (data_rvalid_i) begin
          data_valid_o  = 1'b1;
          access_err    = lsu_err_q | data_err_i; // report once, at completion
          second_part_d = 1'b0;
          ls_fsm_ns     = IDLE;
        end
      end

      WAIT_RVALID_DONE: begin
        if (data_rvalid_i) begin
          lsu_err_d    = data_err_i;
          rdata_update = 1'b1; // first response, second still outstanding
          ls_fsm_ns    = WAIT_RVALID;
        end
      end

      default: ls_fsm_ns = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs     <= IDLE;
      second_part_q <= 1'b0;
      lsu_err_q     <= 1'b0;
    end else begin
      ls_fsm_cs     <= ls_fsm_ns;
      second_part_q <= second_part_d;
      lsu_err_q     <= lsu_err_d;
    end
  end

  // core holds the write flag until data_valid_o, so it selects the error kind
  assign load_err_o  = access_err & ~data_we_ex_i;
  assign store_err_o = access_err &  data_we_ex_i;
  assign busy_o      = (ls_fsm_cs != IDLE) | data_req_ex_i;

  // attributes for the aligners
  assign acc.acc_type     = data_type_ex_i;
  assign acc.acc_offset   = offset;
  assign acc.acc_sign_ext = data_sign_ext_ex_i;
  assign acc.acc_we       = data_we_ex_i;
  assign acc.second_part  = second_part_q;
  assign acc.ctrl_update  = ctrl_update;
  assign acc.rdata_update = rdata_update;

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  state_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ls_fsm_cs inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID,
                        WAIT_RVALID_DONE})
    else $error("lsu_ctrl: invalid FSM state");

  // a response without an outstanding transfer means the bus broke ordering
  rvalid_expected_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_rvalid_i |-> ls_fsm_cs inside {WAIT_RVALID_MIS, WAIT_RVALID, WAIT_RVALID_DONE})
    else $error("lsu_ctrl: response valid without an outstanding transfer");

  err_with_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_err_i |-> data_rvalid_i)
    else $error("lsu_ctrl: bus error outside a response");

  addr_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_o |-> (data_addr_o[$bits(offset_t)-1:0] == '0))
    else $error("lsu_ctrl: bus address not word aligned");

endmodule

/* design/lsu_store_align.sv */
////////////////////////////////////////////////////////////////////////////
// byte enables per transfer and store data lane rotation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_store_align
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
(
  input  data_t data_wdata_ex_i,
  output be_t   data_be_o,
  output data_t data_wdata_o,
  lsu_access_if.store acc
);

  be_t                 be_mask;   // lanes of the access when aligned to lane 0
  logic [2*BE_W-1:0]   be_wide;   // mask placed at the offset, may spill over
  logic [2*DATA_W-1:0] wdata_dbl; // doubled word shifted left gives a rotation

  always_comb begin
    unique case (acc.acc_type)
      TYPE_WORD: be_mask = '1;
      TYPE_HALF: be_mask = BE_W'(2'b11);
      TYPE_BYTE: be_mask = BE_W'(1'b1);
      default:   be_mask = BE_W'(1'b1); // spare code is a byte
    endcase
  end

  // low half serves the first part, the spill is the second part's lanes
  assign be_wide    = {{BE_W{1'b0}}, be_mask} << acc.acc_offset;
  assign data_be_o  = acc.second_part ? be_wide[2*BE_W-1:BE_W] : be_wide[BE_W-1:0];

  // rotate by offset bytes so one word fits both parts
  assign wdata_dbl    = {data_wdata_ex_i, data_wdata_ex_i} << {acc.acc_offset, 3'b000};
  assign data_wdata_o = wdata_dbl[2*DATA_W-1 -: DATA_W];

  // the controller never sets second_part for an access that fits one word
  always_comb begin
    be_nonzero_a: assert final (
        $isunknown({acc.acc_type, acc.acc_offset, acc.second_part}) || (data_be_o != '0))
      else $error("lsu_store_align: empty byte enables for a known access");
  end

endmodule

/* design/lsu_load_align.sv */
////////////////////////////////////////////////////////////////////////////
// load attribute capture and first response register
// word realignment across two responses, zero or sign extension
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_load_align
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  data_t data_rdata_i,
  output data_t data_rdata_ex_o,
  lsu_access_if.load acc
);

  offset_t             offset_q;   // byte offset of the outstanding access
  mem_type_t           type_q;
  logic                sign_ext_q;
  logic [DATA_W-1:8]   rdata_q;    // upper bytes of the first response
  logic                split_acc;
  logic [2*DATA_W-1:0] rdata_pair; // second response above the stored bytes
  data_t               rdata_w;    // access value starting at bit 0
  data_t               rdata_ext;

  // attributes for the response, refreshed on every grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= OFFSET_ALIGNED;
      type_q     <= TYPE_WORD;
      sign_ext_q <= 1'b0;
    end else if (acc.ctrl_update) begin
      offset_q   <= acc.acc_offset;
      type_q     <= acc.acc_type;
      sign_ext_q <= acc.acc_sign_ext;
    end
  end

  // lane 0 of the first response is never part of a split access
  always_ff @(posedge clk_i) begin
    if (acc.rdata_update && !acc.acc_we) begin
      rdata_q <= data_rdata_i[DATA_W-1:8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // realignment and extension
  ////////////////////////////////////////////////////////////////////////////

  assign split_acc =
      ((type_q == TYPE_WORD) && (offset_q != OFFSET_ALIGNED)) ||
      ((type_q == TYPE_HALF) && (offset_q == OFFSET_HALF_SPLIT));

  // low filler byte is never selected, split offsets start at 1
  assign rdata_pair = {data_rdata_i, rdata_q, 8'h00};

  // split: stored bytes low, current response high, else plain shift down
  assign rdata_w = split_acc ? rdata_pair[{offset_q, 3'b000} +: DATA_W]
                             : data_rdata_i >> {offset_q, 3'b000};

  always_comb begin
    unique case (type_q)
      TYPE_WORD: rdata_ext = rdata_w;
      TYPE_HALF: rdata_ext = {{(DATA_W-16){sign_ext_q & rdata_w[15]}}, rdata_w[15:0]};
      default:   rdata_ext = {{(DATA_W-8){sign_ext_q & rdata_w[7]}}, rdata_w[7:0]}; // byte
    endcase
  end

  assign data_rdata_ex_o = rdata_ext; // valid in the final response cycle

endmodule

/* design/lsu_top.sv */
////////////////////////////////////////////////////////////////////////////
// load/store unit top level
// core and bus ports around controller, store and load aligners
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_top
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // data bus
  output logic      data_req_o,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  logic      data_err_i,
  output addr_t     data_addr_o,
  output logic      data_we_o,
  output be_t       data_be_o,
  output data_t     data_wdata_o,
  input  data_t     data_rdata_i,
  // core execute stage
  input  logic      data_req_ex_i,
  input  logic      data_we_ex_i,
  input  mem_type_t data_type_ex_i,
  input  data_t     data_wdata_ex_i,
  input  logic      data_sign_ext_ex_i,
  input  addr_t     adder_result_ex_i,  // byte address from the ALU
  output data_t     data_rdata_ex_o,
  output logic      data_valid_o,       // one cycle, access complete
  output logic      load_err_o,
  output logic      store_err_o,
  output logic      busy_o
);

  lsu_access_if acc_if ();

  lsu_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .data_req_ex_i,
    .data_type_ex_i,
    .data_we_ex_i,
    .data_sign_ext_ex_i,
    .addr_ex_i          (adder_result_ex_i),
    .data_gnt_i,
    .data_rvalid_i,
    .data_err_i,
    .data_req_o,
    .data_addr_o,
    .data_valid_o,
    .load_err_o,
    .store_err_o,
    .busy_o,
    .acc                (acc_if.ctrl)
  );

  lsu_store_align u_store_align (
    .data_wdata_ex_i,
    .data_be_o,
    .data_wdata_o,
    .acc             (acc_if.store)
  );

  lsu_load_align u_load_align (
    .clk_i,
    .rst_ni,
    .data_rdata_i,
    .data_rdata_ex_o,
    .acc             (acc_if.load)
  );

  assign data_we_o = data_we_ex_i; // core holds it for the whole access

endmodule

/* verification/tb_lsu.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the load/store unit top level
// bus memory model with random grant and response delays, access table
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_lsu
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;
();

  localparam int NUM_ROWS       = 19;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 12 + 50;
  localparam int ROW_WAIT       = 20;  // cycles allowed for one access

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  addr_t     data_addr_o, adder_result_ex_i;
  be_t       data_be_o;
  data_t     data_wdata_o, data_rdata_i, data_wdata_ex_i, data_rdata_ex_o;
  logic      data_req_ex_i, data_we_ex_i, data_sign_ext_ex_i;
  mem_type_t data_type_ex_i;
  logic      data_valid_o, load_err_o, store_err_o, busy_o;

  // access table
  addr_t     row_addr  [NUM_ROWS];
  mem_type_t row_size  [NUM_ROWS];
  logic      row_we    [NUM_ROWS];
  logic      row_sign  [NUM_ROWS];
  data_t     row_wdata [NUM_ROWS];
  data_t     row_exp   [NUM_ROWS];
  logic      row_err   [NUM_ROWS];  // access touches an error word
  int        row_cnt = 0;

  // bus model state
  data_t       mem [16];
  int          gnt_cnt = 0;           // cycles left before the next grant
  logic        req_seen, grant_seen, resp_seen;
  data_t       grant_rdata;
  logic        grant_err;
  data_t       pend_rdata[$];
  logic        pend_err[$];
  int unsigned pend_ready[$];         // cycle in which the response goes out
  addr_t       gnt_addr [4];          // grants of the current access
  int          gnt_num;
  int unsigned cycle_cnt = 0;
  logic [31:0] lfsr_q = 32'h0549_b39e;
  int          errors = 0;

  lsu_top dut_i (.*);

  assign data_gnt_i = data_req_o && (gnt_cnt == 0);

  always #4 clk_i = ~clk_i;

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int unsigned val);
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      val    = (val << 1) | lfsr_q[0]; // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic add_row(input addr_t a, input mem_type_t s, input logic we,
                         input logic sign, input data_t wd, input data_t exp,
                         input logic err);
    row_addr[row_cnt]  = a;
    row_size[row_cnt]  = s;
    row_we[row_cnt]    = we;
    row_sign[row_cnt]  = sign;
    row_wdata[row_cnt] = wd;
    row_exp[row_cnt]   = exp;
    row_err[row_cnt]   = err;
    row_cnt++;
  endtask

  // word across a boundary, or half word in lane 3
  function automatic logic needs_split(input mem_type_t s, input offset_t off);
    needs_split = ((s == TYPE_WORD) && (off != 2'd0)) ||
                  ((s == TYPE_HALF) && (off == 2'd3));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////////////////////////////////////////

  // sample at the falling edge, the DUT sees the same values at the next rise
  always @(negedge clk_i) begin : bus_sample
    int b;
    req_seen   = rst_ni && data_req_o;
    grant_seen = rst_ni && data_req_o && data_gnt_i;
    resp_seen  = rst_ni && data_rvalid_i;
    if (grant_seen) begin
      if (data_addr_o[1:0] != 2'b00) begin
        $display("Error: data_addr_o = %h, not word aligned", data_addr_o);
        errors++;
      end
      if (gnt_num < 4) gnt_addr[gnt_num] = data_addr_o;
      gnt_num++;
      grant_err = data_addr_o[6];       // upper half of the map answers with an error
      if (data_we_o && !grant_err) begin
        for (b = 0; b < 4; b++) begin
          if (data_be_o[b]) mem[data_addr_o[5:2]][8*b +: 8] = data_wdata_o[8*b +: 8];
        end
      end
      grant_rdata = mem[data_addr_o[5:2]];
    end
  end

  always @(posedge clk_i) begin : bus_drive
    int unsigned delay;
    #1;
    if (!rst_ni) begin
      data_rvalid_i = 1'b0;
      data_err_i    = 1'b0;
      data_rdata_i  = '0;
      gnt_cnt       = 0;
    end else begin
      if (resp_seen && pend_ready.size() > 0) begin
        void'(pend_rdata.pop_front());
        void'(pend_err.pop_front());
        void'(pend_ready.pop_front());
      end
      if (grant_seen) begin
        draw_bits(1, delay);            // response 1 or 2 cycles after grant
        pend_rdata.push_back(grant_rdata);
        pend_err.push_back(grant_err);
        pend_ready.push_back(cycle_cnt + delay);
        draw_bits(2, delay);
        gnt_cnt = delay % 3;            // next grant after 0 to 2 cycles
      end else if (req_seen && gnt_cnt > 0) begin
        gnt_cnt--;
      end
      if (pend_ready.size() > 0 && cycle_cnt >= pend_ready[0]) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = pend_rdata[0];
        data_err_i    = pend_err[0];
      end else begin
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        data_err_i    = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks at completion
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_completion(input int r);
    logic  split;
    addr_t base;
    split = needs_split(row_size[r], row_addr[r][1:0]);
    base  = {row_addr[r][ADDR_W-1:2], 2'b00};
    if (!row_we[r] && !row_err[r] && data_rdata_ex_o !== row_exp[r]) begin
      $display("Error: row %0d data_rdata_ex_o = %h, expected %h", r, data_rdata_ex_o,
               row_exp[r]);
      errors++;
    end
    if (load_err_o !== (row_err[r] & ~row_we[r])) begin
      $display("Error: row %0d load_err_o = %h, expected %h", r, load_err_o,
               row_err[r] & ~row_we[r]);
      errors++;
    end
    if (store_err_o !== (row_err[r] & row_we[r])) begin
      $display("Error: row %0d store_err_o = %h, expected %h", r, store_err_o,
               row_err[r] & row_we[r]);
      errors++;
    end
    if (gnt_num != (split ? 2 : 1)) begin
      $display("Error: row %0d grant count = %h, expected %h", r, gnt_num, split ? 2 : 1);
      errors++;
    end else if (gnt_addr[0] !== base) begin
      $display("Error: row %0d data_addr_o = %h, expected %h", r, gnt_addr[0], base);
      errors++;
    end else if (split && gnt_addr[1] !== base + 32'd4) begin
      $display("Error: row %0d data_addr_o = %h, expected %h", r, gnt_addr[1],
               base + 32'd4);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int   r;
    int   i;
    int   waited;
    logic done;
    logic stop;
    rst_ni             = 1'b0;
    data_req_ex_i      = 1'b0;
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = TYPE_WORD;
    data_sign_ext_ex_i = 1'b0;
    data_wdata_ex_i    = '0;
    adder_result_ex_i  = '0;
    data_rvalid_i      = 1'b0;
    data_err_i         = 1'b0;
    data_rdata_i       = '0;
    gnt_num            = 0;
    stop               = 1'b0;
    // byte at address a holds a + 0x70
    for (i = 0; i < 64; i++) mem[i / 4][8*(i % 4) +: 8] = 8'(i + 8'h70);

    // addr, size, we, sign, store data, expected load value, error word
    add_row(32'h00, TYPE_WORD, 0, 0, 32'h0, 32'h7372_7170, 0);
    add_row(32'h06, TYPE_HALF, 0, 0, 32'h0, 32'h0000_7776, 0);
    add_row(32'h12, TYPE_HALF, 0, 1, 32'h0, 32'hFFFF_8382, 0);
    add_row(32'h11, TYPE_BYTE, 0, 1, 32'h0, 32'hFFFF_FF81, 0);
    add_row(32'h11, TYPE_BYTE, 0, 0, 32'h0, 32'h0000_0081, 0);
    add_row(32'h05, TYPE_WORD, 0, 0, 32'h0, 32'h7877_7675, 0); // split, offset 1
    add_row(32'h0A, TYPE_WORD, 0, 0, 32'h0, 32'h7D7C_7B7A, 0); // offset 2
    add_row(32'h0F, TYPE_WORD, 0, 0, 32'h0, 32'h8281_807F, 0); // offset 3
    add_row(32'h0F, TYPE_HALF, 0, 1, 32'h0, 32'hFFFF_807F, 0); // half over lane 3
    add_row(32'h21, TYPE_BYTE, 1, 0, 32'h0000_00AB, 32'h0, 0);
    add_row(32'h20, TYPE_WORD, 0, 0, 32'h0, 32'h9392_AB90, 0);
    add_row(32'h26, TYPE_WORD, 1, 0, 32'hDDCC_BBAA, 32'h0, 0); // store over two words
    add_row(32'h24, TYPE_WORD, 0, 0, 32'h0, 32'hBBAA_9594, 0);
    add_row(32'h28, TYPE_WORD, 0, 0, 32'h0, 32'h9B9A_DDCC, 0);
    add_row(32'h2F, TYPE_HALF, 1, 0, 32'h0000_1234, 32'h0, 0);
    add_row(32'h2D, TYPE_WORD, 0, 0, 32'h0, 32'h1234_9E9D, 0);
    add_row(32'h40, TYPE_WORD, 0, 0, 32'h0, 32'h0, 1);         // error word
    add_row(32'h3E, TYPE_WORD, 0, 0, 32'h0, 32'h0, 1);         // second part errs
    add_row(32'h7F, TYPE_HALF, 1, 0, 32'h0000_5566, 32'h0, 1); // first part errs

    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    for (r = 0; r < row_cnt && !stop; r++) begin
      @(posedge clk_i);
      #1;
      gnt_num            = 0;
      data_req_ex_i      = 1'b1;
      adder_result_ex_i  = row_addr[r];
      data_type_ex_i     = row_size[r];
      data_we_ex_i       = row_we[r];
      data_sign_ext_ex_i = row_sign[r];
      data_wdata_ex_i    = row_wdata[r];
      done               = 1'b0;
      waited             = 0;
      while (!done && waited < ROW_WAIT) begin
        @(negedge clk_i);
        if (busy_o !== 1'b1) begin
          $display("Error: row %0d busy_o = %h, expected 1", r, busy_o);
          errors++;
        end
        if (data_valid_o) begin
          check_completion(r);
          done = 1'b1;
        end
        waited++;
      end
      if (!done) begin
        $display("row %0d: access did not complete within %0d cycles", r, ROW_WAIT);
        errors++;
        stop = 1'b1;
      end else begin
        // one idle cycle between accesses, the unit must go quiet
        @(posedge clk_i);
        #1 data_req_ex_i = 1'b0;
        @(negedge clk_i);
        if (busy_o !== 1'b0) begin
          $display("Error: row %0d busy_o = %h, expected 0", r, busy_o);
          errors++;
        end
      end
    end

    @(posedge clk_i);
    #1 data_req_ex_i = 1'b0;
    repeat (3) @(posedge clk_i);
    if (pend_ready.size() != 0) begin
      $display("bus transfers still outstanding after the last access");
      errors++;
    end

    $display("rows run: %0d, errors: %0d", r, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // run limit scales with the table length
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: simulation ran past %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule

/* build.f */
design/lsu_bus_pkg.sv
design/lsu_access_pkg.sv
design/lsu_access_if.sv
design/lsu_ctrl.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_top.sv
verification/tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - design/lsu_bus_pkg.sv
  - design/lsu_access_pkg.sv
  - design/lsu_access_if.sv
  - design/lsu_ctrl.sv
  - design/lsu_store_align.sv
  - design/lsu_load_align.sv
  - design/lsu_top.sv
  - target: test
    files:
      - verification/tb_lsu.sv
